//--- common/aluPkg.sv
// ----------------------------------------------------------
// shared types for the bit-slice alu
// ----------------------------------------------------------
package aluPkg;

  // operation code seen at the alu boundary
  // all eight codes of the 3-bit field are in use
  typedef enum logic [2:0] {
    opAdd  = 3'd0,
    opSub  = 3'd1,
    opSlt  = 3'd2,
    opAnd  = 3'd3,
    opOr   = 3'd4,
    opXor  = 3'd5,
    opNand = 3'd6,
    opNor  = 3'd7
  } aluOp_t;

  // gate evaluated inside every slice
  // codes 5 to 7 are never produced by the decoder
  typedef enum logic [2:0] {
    lgAnd  = 3'd0,
    lgOr   = 3'd1,
    lgXor  = 3'd2,
    lgNand = 3'd3,
    lgNor  = 3'd4
  } logicOp_t;

  // how the result stage finishes a request
  // rkLogic  gate output, carry and overflow forced low
  // rkArith  adder output with carry and overflow
  // rkLess   signed set-less-than bit, zero extended
  typedef enum logic [1:0] {
    rkLogic = 2'd0,
    rkArith = 2'd1,
    rkLess  = 2'd2
  } resultKind_t;

  // ----------------------------------------------------------
  // control structs
  // ----------------------------------------------------------

  // per-slice control, identical for every bit
  typedef struct packed {
    logic     invertB;   // b goes into the adder inverted
    logic     useSum;    // result bit comes from the adder
    logicOp_t logicSel;  // gate used when useSum is low
  } sliceCtrl_t;

  // everything the first stage hands downstream
  typedef struct packed {
    sliceCtrl_t  slice;
    resultKind_t kind;
  } stageCtrl_t;

  // status reported alongside the result
  typedef struct packed {
    logic carryOut;
    logic overflow;
    logic zero;
  } aluFlags_t;

endpackage

//--- alu/aluSlice.sv
`timescale 1ns/100ps

// ----------------------------------------------------------
// one bit of the datapath
// full adder with optional b inversion plus a gate selector
// ----------------------------------------------------------
module aluSlice (
  input  logic               a,
  input  logic               b,
  input  logic               carryIn,
  input  aluPkg::sliceCtrl_t ctrl,
  output logic               sum,
  output logic               carryOut,
  output logic               resultBit
);

  logic bAdd;
  logic gateOut;

  // b as seen by the adder
  assign bAdd = b ^ ctrl.invertB;

  // ----------------------------------------------------------
  // full adder
  // ----------------------------------------------------------

  // three-input parity
  assign sum = a ^ bAdd ^ carryIn;

  // majority of the three adder inputs
  assign carryOut = (a & bAdd) | (a & carryIn) | (bAdd & carryIn);

  // ----------------------------------------------------------
  // gate function
  // ----------------------------------------------------------

  // gates always see the uninverted b
  always_comb begin
    case (ctrl.logicSel)
      aluPkg::lgAnd: begin
        gateOut = a & b;
      end
      aluPkg::lgOr: begin
        gateOut = a | b;
      end
      aluPkg::lgXor: begin
        gateOut = a ^ b;
      end
      // nand of a value with itself gives not
      aluPkg::lgNand: begin
        gateOut = ~(a & b);
      end
      aluPkg::lgNor: begin
        gateOut = ~(a | b);
      end
      // unused codes fall back to and
      default: begin
        gateOut = a & b;
      end
    endcase
  end

  // output select
  assign resultBit = ctrl.useSum ? sum : gateOut;

endmodule

//--- alu/opDecoder.sv
`timescale 1ns/100ps

// ----------------------------------------------------------
// first pipeline stage
// captures the request and turns the opcode into slice control
// ----------------------------------------------------------
module opDecoder #(
  parameter int width = 32
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  aluPkg::aluOp_t      op,
  input  logic [width-1:0]    operandA,
  input  logic [width-1:0]    operandB,
  output logic [width-1:0]    latchedA,
  output logic [width-1:0]    latchedB,
  output aluPkg::stageCtrl_t  ctrl,
  output logic                stageValid
);

  aluPkg::stageCtrl_t nextCtrl;

  // opcode translation
  always_comb begin
    // logic defaults, overridden below for the adder ops
    nextCtrl.slice.invertB  = 1'b0;
    nextCtrl.slice.useSum   = 1'b0;
    nextCtrl.slice.logicSel = aluPkg::lgAnd;
    nextCtrl.kind           = aluPkg::rkLogic;
    case (op)
      aluPkg::opAdd: begin
        nextCtrl.slice.useSum = 1'b1;
        nextCtrl.kind         = aluPkg::rkArith;
      end
      // sub is a + ~b + 1, the +1 comes in on carry 0
      aluPkg::opSub: begin
        nextCtrl.slice.invertB = 1'b1;
        nextCtrl.slice.useSum  = 1'b1;
        nextCtrl.kind          = aluPkg::rkArith;
      end
      // slt runs the same subtraction and keeps only the sign test
      aluPkg::opSlt: begin
        nextCtrl.slice.invertB = 1'b1;
        nextCtrl.slice.useSum  = 1'b1;
        nextCtrl.kind          = aluPkg::rkLess;
      end
      aluPkg::opOr:   nextCtrl.slice.logicSel = aluPkg::lgOr;
      aluPkg::opXor:  nextCtrl.slice.logicSel = aluPkg::lgXor;
      aluPkg::opNand: nextCtrl.slice.logicSel = aluPkg::lgNand;
      aluPkg::opNor:  nextCtrl.slice.logicSel = aluPkg::lgNor;
      default:        nextCtrl.slice.logicSel = aluPkg::lgAnd;
    endcase
  end

  // control registers
  always_ff @(posedge clk) begin
    if (reset) begin
      stageValid <= 1'b0;
      ctrl       <= '0;
    end else begin
      stageValid <= start;
      if (start) begin
        ctrl <= nextCtrl;
      end
    end
  end

  // operand registers
  always_ff @(posedge clk) begin
    if (start) begin
      latchedA <= operandA;
      latchedB <= operandB;
    end
  end

  // a request must carry a known opcode
  assert property (@(posedge clk) disable iff (reset) start |-> !$isunknown(op));

  // adder output is selected for exactly the arith and less kinds
  assert property (@(posedge clk) disable iff (reset)
    stageValid |-> (ctrl.slice.useSum == (ctrl.kind != aluPkg::rkLogic)));

endmodule

//--- alu/resultStage.sv
`timescale 1ns/100ps

// ----------------------------------------------------------
// second pipeline stage
// derives flags and slt from the slice outputs and registers them
// ----------------------------------------------------------
module resultStage #(
  parameter int width = 32
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 stageValid,
  input  aluPkg::resultKind_t  kind,
  input  logic [width-1:0]     sliceResult,
  input  logic                 msbSum,
  input  logic                 carryIntoMsb,
  input  logic                 carryOutOfMsb,
  output logic [width-1:0]     result,
  output aluPkg::aluFlags_t    flags,
  output logic                 done
);

  logic              overflow;
  logic              lessBit;
  logic [width-1:0]  nextResult;
  aluPkg::aluFlags_t nextFlags;

  // ----------------------------------------------------------
  // arithmetic status
  // ----------------------------------------------------------

  // signed overflow when the carries around the top bit disagree
  assign overflow = carryIntoMsb ^ carryOutOfMsb;

  // the sign of a - b is wrong exactly when the subtraction overflowed
  assign lessBit = msbSum ^ overflow;

  // ----------------------------------------------------------
  // final result and flags
  // ----------------------------------------------------------
  always_comb begin
    nextResult         = sliceResult;
    nextFlags.carryOut = 1'b0;
    nextFlags.overflow = 1'b0;
    case (kind)
      aluPkg::rkArith: begin
        nextFlags.carryOut = carryOutOfMsb;
        nextFlags.overflow = overflow;
      end
      aluPkg::rkLess: begin
        nextResult = {{(width-1){1'b0}}, lessBit};
      end
      // gate output passes untouched
      default: begin
        nextResult = sliceResult;
      end
    endcase
    // zero looks at what is actually reported
    nextFlags.zero = (nextResult == '0);
  end

  // output registers
  // result and flags hold between done pulses
  always_ff @(posedge clk) begin
    if (reset) begin
      done   <= 1'b0;
      result <= '0;
      flags  <= '0;
    end else begin
      done <= stageValid;
      if (stageValid) begin
        result <= nextResult;
        flags  <= nextFlags;
      end
    end
  end

  // every done pulse comes from a request one cycle earlier
  assert property (@(posedge clk) disable iff (reset) done |-> $past(stageValid));

  // reported zero flag agrees with the reported result
  assert property (@(posedge clk) disable iff (reset)
    done |-> (flags.zero == (result == '0)));

endmodule

//--- hw/aluTop.sv
`timescale 1ns/100ps

// ----------------------------------------------------------
// bit-slice alu top level
// decoder, slice array with ripple carry, result stage
// ----------------------------------------------------------
module aluTop #(
  parameter int width = 32
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  aluPkg::aluOp_t     op,
  input  logic [width-1:0]   operandA,
  input  logic [width-1:0]   operandB,
  output logic [width-1:0]   result,
  output aluPkg::aluFlags_t  flags,
  output logic               done
);

  logic [width-1:0]   latchedA;
  logic [width-1:0]   latchedB;
  aluPkg::stageCtrl_t ctrl;
  logic               stageValid;
  logic [width:0]     carry;
  logic [width-1:0]   sliceResult;
  logic               msbSum;

  // request capture and decode
  opDecoder #(.width(width)) decoder (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .op         (op),
    .operandA   (operandA),
    .operandB   (operandB),
    .latchedA   (latchedA),
    .latchedB   (latchedB),
    .ctrl       (ctrl),
    .stageValid (stageValid)
  );

  // carry 0 supplies the +1 of a two's complement subtract
  assign carry[0] = ctrl.slice.invertB;

  // ----------------------------------------------------------
  // slice array, carry ripples upward
  // ----------------------------------------------------------
  for (genvar i = 0; i < width; i++) begin : gSlice
    logic bitSum;

    aluSlice slice (
      .a         (latchedA[i]),
      .b         (latchedB[i]),
      .carryIn   (carry[i]),
      .ctrl      (ctrl.slice),
      .sum       (bitSum),
      .carryOut  (carry[i+1]),
      .resultBit (sliceResult[i])
    );

    // only the top sum feeds the less-than test
    if (i == width - 1) begin : gMsb
      assign msbSum = bitSum;
    end
  end

  // flags, slt and output registers
  resultStage #(.width(width)) resStage (
    .clk           (clk),
    .reset         (reset),
    .stageValid    (stageValid),
    .kind          (ctrl.kind),
    .sliceResult   (sliceResult),
    .msbSum        (msbSum),
    .carryIntoMsb  (carry[width-1]),
    .carryOutOfMsb (carry[width]),
    .result        (result),
    .flags         (flags),
    .done          (done)
  );

endmodule

//--- tests/aluModel.svh
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// expected outcome of one request
typedef struct packed {
  aluPkg::aluOp_t    op;
  logic [width-1:0]  result;
  aluPkg::aluFlags_t flags;
} modelOut_t;

// reference model, works on whole words
function automatic modelOut_t predictAlu(input aluPkg::aluOp_t op,
                                         input logic [width-1:0] a,
                                         input logic [width-1:0] b);
  logic [width:0]   total;
  logic [width-1:0] lowTotal;
  logic [width-1:0] bAdd;
  logic             subtract;
  logic             msbCarryIn;
  logic             ovf;
  modelOut_t        prediction;
  // sub and slt both form a + ~b + 1
  subtract = (op == aluPkg::opSub) || (op == aluPkg::opSlt);
  bAdd = subtract ? ~b : b;
  total = {1'b0, a} + {1'b0, bAdd} + subtract;
  // carry into the top bit comes out of the lower width-1 bits
  lowTotal = {1'b0, a[width-2:0]} + {1'b0, bAdd[width-2:0]} + subtract;
  msbCarryIn = lowTotal[width-1];
  ovf = msbCarryIn ^ total[width];
  prediction.op = op;
  prediction.flags = '0;
  prediction.result = '0;
  case (op)
    aluPkg::opAdd, aluPkg::opSub: begin
      prediction.result = total[width-1:0];
      prediction.flags.carryOut = total[width];
      prediction.flags.overflow = ovf;
    end
    // signed less-than, sign of the difference corrected by overflow
    aluPkg::opSlt:  prediction.result[0] = total[width-1] ^ ovf;
    aluPkg::opAnd:  prediction.result = a & b;
    aluPkg::opOr:   prediction.result = a | b;
    aluPkg::opXor:  prediction.result = a ^ b;
    aluPkg::opNand: prediction.result = ~(a & b);
    default:        prediction.result = ~(a | b);
  endcase
  prediction.flags.zero = (prediction.result == '0);
  return prediction;
endfunction

`endif

//--- tests/aluTb.sv
`timescale 1ns/100ps

module aluTb;

  localparam int width        = 32;
  localparam int resetCycles  = 16;
  localparam int numRequests  = 2000;
  localparam int drainCycles  = 8;
  // directed requests and idle slack fit in the margin
  localparam int marginCycles = 576;
  localparam int maxCycles    = resetCycles + numRequests + drainCycles + marginCycles;

  `include "aluModel.svh"

  logic              clk = 1'b0;
  logic              reset;
  logic              start;
  aluPkg::aluOp_t    op;
  logic [width-1:0]  operandA;
  logic [width-1:0]  operandB;
  logic [width-1:0]  result;
  aluPkg::aluFlags_t flags;
  logic              done;

  integer            seed;
  integer            cycleCount;
  logic              pend1;
  logic              pend2;
  logic [width-1:0]  heldResult;
  aluPkg::aluFlags_t heldFlags;
  modelOut_t         expQueue[$];

  aluTop #(.width(width)) i_dut (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .op       (op),
    .operandA (operandA),
    .operandB (operandB),
    .result   (result),
    .flags    (flags),
    .done     (done)
  );

  // 4 ns clock
  always #2 clk = ~clk;

  // ----------------------------------------------------------
  // failure reporting
  // ----------------------------------------------------------
  task automatic stopWithFailure();
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkValue(input string testName, input logic [63:0] expected,
                            input logic [63:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s expected %0h actual %0h", testName, expected, actual);
      stopWithFailure();
    end
  endtask

  // ----------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------

  // one time in four a corner value
  function automatic logic [width-1:0] pickOperand();
    integer           pick;
    logic [width-1:0] value;
    pick = $random(seed);
    if (pick[1:0] == 2'd0) begin
      case (pick[3:2])
        2'd0:    value = '0;
        2'd1:    value = '1;
        2'd2:    value = {1'b1, {(width-1){1'b0}}};
        default: value = {1'b0, {(width-1){1'b1}}};
      endcase
    end else begin
      value = $random(seed);
    end
    return value;
  endfunction

  task automatic sendRequest(input aluPkg::aluOp_t reqOp, input logic [width-1:0] a,
                             input logic [width-1:0] b);
    @(posedge clk);
    start    <= 1'b1;
    op       <= reqOp;
    operandA <= a;
    operandB <= b;
    expQueue.push_back(predictAlu(reqOp, a, b));
  endtask

  // junk on the operand pins must not be captured
  task automatic idleCycle();
    @(posedge clk);
    start    <= 1'b0;
    operandA <= $random(seed);
    operandB <= $random(seed);
  endtask

  // ----------------------------------------------------------
  // latency model and timeout
  // ----------------------------------------------------------

  // done follows the sampled start by two edges
  always @(posedge clk) begin
    if (reset) begin
      pend1 <= 1'b0;
      pend2 <= 1'b0;
    end else begin
      pend1 <= start;
      pend2 <= pend1;
    end
  end

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= maxCycles) begin
      $display("timeout after %0d cycles, the run did not finish", cycleCount);
      stopWithFailure();
    end
  end

  // ----------------------------------------------------------
  // output monitor sampled mid-cycle
  // ----------------------------------------------------------
  always @(negedge clk) begin
    modelOut_t expected;
    if (reset) begin
      checkValue("reset done", 64'd0, done);
      checkValue("reset result", 64'd0, result);
      checkValue("reset flags", 64'd0, flags);
    end else begin
      checkValue("done latency", pend2, done);
      if (done) begin
        if (expQueue.size() == 0) begin
          $display("done pulse arrived with no request outstanding");
          stopWithFailure();
        end else begin
          expected = expQueue.pop_front();
          checkValue({expected.op.name(), " result"}, expected.result, result);
          checkValue({expected.op.name(), " carry"}, expected.flags.carryOut,
                     flags.carryOut);
          checkValue({expected.op.name(), " overflow"}, expected.flags.overflow,
                     flags.overflow);
          checkValue({expected.op.name(), " zero"}, expected.flags.zero, flags.zero);
          // outputs keep these values until the next done
          heldResult = expected.result;
          heldFlags  = expected.flags;
        end
      end else begin
        // between pulses the outputs show the last finished request
        checkValue("held result", heldResult, result);
        checkValue("held flags", heldFlags, flags);
      end
    end
  end

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial begin
    integer         r;
    aluPkg::aluOp_t pickOp;
    reset      = 1'b1;
    start      = 1'b0;
    op         = aluPkg::opAdd;
    operandA   = '0;
    operandB   = '0;
    seed       = 6065;
    cycleCount = 0;
    // outputs leave reset cleared
    heldResult = '0;
    heldFlags  = '0;
    repeat (resetCycles) @(posedge clk);
    reset <= 1'b0;
    // directed corners sent back to back
    r = $random(seed);
    sendRequest(aluPkg::opSub, r, r);
    sendRequest(aluPkg::opNand, '1, '1);
    sendRequest(aluPkg::opNand, r, '1);
    sendRequest(aluPkg::opSlt, {1'b1, {(width-1){1'b0}}}, {1'b0, {(width-1){1'b1}}});
    sendRequest(aluPkg::opSlt, {1'b0, {(width-1){1'b1}}}, {1'b1, {(width-1){1'b0}}});
    sendRequest(aluPkg::opAdd, {1'b0, {(width-1){1'b1}}}, 1);
    sendRequest(aluPkg::opSub, {1'b1, {(width-1){1'b0}}}, 1);
    sendRequest(aluPkg::opAdd, '1, 1);
    idleCycle();
    // random mix with start high about three cycles in four
    for (int i = 0; i < numRequests; i++) begin
      r = $random(seed);
      pickOp = aluPkg::aluOp_t'(r[6:4]);
      if (r[3:2] != 2'd0) begin
        sendRequest(pickOp, pickOperand(), pickOperand());
      end else begin
        idleCycle();
      end
    end
    idleCycle();
    repeat (drainCycles) @(posedge clk);
    if (expQueue.size() != 0) begin
      $display("%0d requests never produced a done pulse", expQueue.size());
      stopWithFailure();
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

//--- compile.f
+incdir+tests
common/aluPkg.sv
alu/aluSlice.sv
alu/opDecoder.sv
alu/resultStage.sv
hw/aluTop.sv
tests/aluTb.sv

//--- Makefile
# Verilator build and run for the bit-slice ALU

VERILATOR ?= verilator
TOP       ?= aluTb
RTL_TOP   ?= aluTop
FLAGS     ?= --assert --timing
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: all build run lint lint-rtl clean

all: run

# compile the testbench into a simulation binary
build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJDIR) -o V$(TOP)

# run and decide pass or fail from the printed output
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

# lint the whole project with the testbench on top
lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# lint the design alone
lint-rtl:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) \
		common/aluPkg.sv alu/aluSlice.sv alu/opDecoder.sv \
		alu/resultStage.sv hw/aluTop.sv

clean:
	rm -rf $(OBJDIR)
